// ==== Makefile ====
run: obj_dir/Vtb_exu_top
	./obj_dir/Vtb_exu_top | tee sim.log
	grep -q "^Simulation passed$$" sim.log

obj_dir/Vtb_exu_top: files.f exu_pkg.sv mem_pkg.sv alu.sv exu_load_master.sv \
		exu_store_master.sv exu.sv dsram.sv exu_top.sv tb_exu_top.sv
	verilator --binary --timing --assert --top-module tb_exu_top -f files.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input  exu_pkg::alu_op_e op,
	input  exu_pkg::data_t   a,
	input  exu_pkg::data_t   b,
	output exu_pkg::data_t   result
);

	logic lt_s;
	logic lt_u;
	logic eq;

	// shared comparators for slt* and the branch ops
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq = a == b;

	always_comb begin
		case (op)
			exu_pkg::ALU_ADD: result = a + b;
			exu_pkg::ALU_SUB: result = a - b;
			exu_pkg::ALU_AND: result = a & b;
			exu_pkg::ALU_OR: result = a | b;
			exu_pkg::ALU_XOR: result = a ^ b;
			exu_pkg::ALU_SLL: result = a << b[4:0];
			exu_pkg::ALU_SRL: result = a >> b[4:0];
			exu_pkg::ALU_SRA: result = $signed(a) >>> b[4:0];
			exu_pkg::ALU_SLT, exu_pkg::ALU_LT: result = {31'b0, lt_s};
			exu_pkg::ALU_SLTU, exu_pkg::ALU_LTU: result = {31'b0, lt_u};
			exu_pkg::ALU_EQ: result = {31'b0, eq};
			exu_pkg::ALU_NE: result = {31'b0, !eq};
			exu_pkg::ALU_GE: result = {31'b0, !lt_s};
			exu_pkg::ALU_GEU: result = {31'b0, !lt_u};
			default: result = a + b;
		endcase
	end

endmodule

// ==== dsram.sv ====
`timescale 1ns/1ps

module dsram #(
	parameter int MEM_WORDS = 1024,
	parameter int RESP_LATENCY = 2
) (
	input  logic                     clk,
	input  logic                     rst,
	input  mem_pkg::addr_t           araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output exu_pkg::data_t           rdata,
	output mem_pkg::resp_t           rresp,
	output logic                     rvalid,
	input  logic                     rready,
	input  mem_pkg::addr_t           awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  exu_pkg::data_t           wdata,
	input  mem_pkg::strb_t           wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output mem_pkg::resp_t           bresp,
	output logic                     bvalid,
	input  logic                     bready
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int CNT_W = $clog2(RESP_LATENCY + 2);

	typedef enum logic [1:0] {S_IDLE, S_WDATA, S_RRESP, S_BRESP} state_e;

	state_e state;
	logic [CNT_W-1:0] cnt;
	exu_pkg::data_t mem [MEM_WORDS];
	exu_pkg::data_t rdata_q;
	mem_pkg::addr_t aw_q;
	mem_pkg::addr_t wr_addr;
	logic do_write;

	// word index wraps at the memory depth
	function automatic logic [IDX_W-1:0] word_idx(input mem_pkg::addr_t a);
		word_idx = IDX_W'(a[31:2] % MEM_WORDS);
	endfunction

	// writes win over reads when both show up in idle
	assign arready = state == S_IDLE && !awvalid;
	assign awready = state == S_IDLE;
	assign wready = state == S_IDLE || state == S_WDATA;

	// data may come with its address or after it
	assign wr_addr = (state == S_IDLE) ? awaddr : aw_q;
	assign do_write = wvalid && (state == S_WDATA || (state == S_IDLE && awvalid));

	assign rvalid = state == S_RRESP && cnt == '0;
	assign bvalid = state == S_BRESP && cnt == '0;
	assign rdata = rdata_q;
	assign rresp = mem_pkg::RESP_OKAY;
	assign bresp = mem_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (awvalid) begin
						state <= wvalid ? S_BRESP : S_WDATA;
						cnt <= CNT_W'(RESP_LATENCY);
					end else if (arvalid) begin
						state <= S_RRESP;
						cnt <= CNT_W'(RESP_LATENCY);
					end
				end
				S_WDATA: begin
					if (wvalid) begin
						state <= S_BRESP;
						cnt <= CNT_W'(RESP_LATENCY);
					end
				end
				S_RRESP: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (rready) begin
						state <= S_IDLE;
					end
				end
				default: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (bready) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			aw_q <= awaddr;
		end
		if (arvalid && arready) begin
			rdata_q <= mem[word_idx(araddr)];
		end
		if (do_write) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					mem[word_idx(wr_addr)][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== exu.sv ====
`timescale 1ns/1ps

module exu (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	output logic                     in_allowin,
	input  exu_pkg::data_t           pc,
	input  exu_pkg::data_t           src1,
	input  exu_pkg::data_t           src2,
	input  exu_pkg::reg_idx_t        rd,
	input  exu_pkg::alu_op_e         alu_op,
	input  exu_pkg::load_kind_e      load_kind,
	input  exu_pkg::store_kind_e     store_kind,
	input  exu_pkg::data_t           store_data,
	input  exu_pkg::jump_kind_e      jump_kind,
	input  logic                     cond_branch,
	input  exu_pkg::data_t           branch_target,
	input  exu_pkg::csr_addr_t       csr_idx,
	input  exu_pkg::csr_kind_e       csr_kind,
	input  exu_pkg::data_t           csr_nextpc,
	input  logic                     csr_nextpc_taken,
	output logic                     out_valid,
	output logic                     nextpc_taken,
	output exu_pkg::data_t           nextpc,
	output logic                     rf_wen,
	output exu_pkg::reg_idx_t        rf_waddr,
	output exu_pkg::data_t           rf_wdata,
	output logic                     csr_wen,
	output exu_pkg::csr_addr_t       csr_waddr,
	output exu_pkg::data_t           csr_wdata,
	output logic                     csr_wen2,
	output exu_pkg::csr_addr_t       csr_waddr2,
	output exu_pkg::data_t           csr_wdata2,
	output mem_pkg::addr_t           araddr,
	output logic                     arvalid,
	input  logic                     arready,
	input  exu_pkg::data_t           rdata,
	input  mem_pkg::resp_t           rresp,
	input  logic                     rvalid,
	output logic                     rready,
	output mem_pkg::addr_t           awaddr,
	output logic                     awvalid,
	input  logic                     awready,
	output exu_pkg::data_t           wdata,
	output mem_pkg::strb_t           wstrb,
	output logic                     wvalid,
	input  logic                     wready,
	input  mem_pkg::resp_t           bresp,
	input  logic                     bvalid,
	output logic                     bready
);

	logic stage_valid;
	exu_pkg::data_t pc_q;
	exu_pkg::data_t src1_q;
	exu_pkg::data_t src2_q;
	exu_pkg::reg_idx_t rd_q;
	exu_pkg::alu_op_e alu_op_q;
	exu_pkg::load_kind_e load_q;
	exu_pkg::store_kind_e store_q;
	exu_pkg::data_t store_data_q;
	exu_pkg::jump_kind_e jump_q;
	logic cond_q;
	exu_pkg::data_t target_q;
	exu_pkg::csr_addr_t csr_idx_q;
	exu_pkg::csr_kind_e csr_kind_q;
	exu_pkg::data_t csr_nextpc_q;
	logic csr_taken_q;

	exu_pkg::data_t alu_result;
	exu_pkg::data_t load_data;
	logic load_done;
	logic store_done;
	logic is_load;
	logic is_store;
	logic ready_go;
	logic cond_taken;
	logic is_ecall;

	assign is_load = load_q != exu_pkg::LD_NONE;
	assign is_store = store_q != exu_pkg::ST_NONE;
	// memory ops hold the stage until their response handshake
	assign ready_go = is_load ? load_done : (is_store ? store_done : 1'b1);
	assign out_valid = stage_valid && ready_go;
	assign in_allowin = !stage_valid || ready_go;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid <= 1'b0;
		end else if (in_allowin) begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_allowin) begin
			pc_q <= pc;
			src1_q <= src1;
			src2_q <= src2;
			rd_q <= rd;
			alu_op_q <= alu_op;
			load_q <= load_kind;
			store_q <= store_kind;
			store_data_q <= store_data;
			jump_q <= jump_kind;
			cond_q <= cond_branch;
			target_q <= branch_target;
			csr_idx_q <= csr_idx;
			csr_kind_q <= csr_kind;
			csr_nextpc_q <= csr_nextpc;
			csr_taken_q <= csr_nextpc_taken;
		end
	end

	alu alu_inst (
		.op(alu_op_q),
		.a(src1_q),
		.b(src2_q),
		.result(alu_result)
	);

	// the ALU sum doubles as the memory address
	exu_load_master load_inst (
		.clk(clk),
		.rst(rst),
		.start(stage_valid && is_load),
		.addr(alu_result),
		.kind(load_q),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.load_done(load_done),
		.load_data(load_data)
	);

	exu_store_master store_inst (
		.clk(clk),
		.rst(rst),
		.start(stage_valid && is_store),
		.addr(alu_result),
		.kind(store_q),
		.data(store_data_q),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.store_done(store_done)
	);

	// branch compares leave their outcome in bit 0
	assign cond_taken = cond_q && alu_result[0];

	always_comb begin
		if (jump_q == exu_pkg::JMP_JAL) begin
			nextpc = alu_result;
		end else if (jump_q == exu_pkg::JMP_JALR) begin
			nextpc = {alu_result[31:1], 1'b0};
		end else if (cond_taken) begin
			nextpc = target_q;
		end else begin
			nextpc = csr_nextpc_q;
		end
	end

	assign nextpc_taken = out_valid && (jump_q != exu_pkg::JMP_NONE || cond_taken || csr_taken_q);

	always_comb begin
		if (jump_q != exu_pkg::JMP_NONE) begin
			rf_wdata = pc_q + 32'd4;
		end else if (is_load) begin
			rf_wdata = load_data;
		end else if (csr_kind_q == exu_pkg::CSR_RW || csr_kind_q == exu_pkg::CSR_RS) begin
			// old csr value arrives in src2
			rf_wdata = src2_q;
		end else begin
			rf_wdata = alu_result;
		end
	end

	assign is_ecall = csr_kind_q == exu_pkg::CSR_ECALL;
	assign rf_waddr = rd_q;
	assign rf_wen = out_valid && !is_store && !cond_q && !is_ecall;

	// csrrs gets src1 | csr through the ALU
	assign csr_wen = out_valid && csr_kind_q != exu_pkg::CSR_NONE;
	assign csr_waddr = is_ecall ? exu_pkg::CSR_MEPC : csr_idx_q;
	assign csr_wdata = (csr_kind_q == exu_pkg::CSR_RW) ? src1_q :
		(csr_kind_q == exu_pkg::CSR_RS) ? alu_result : pc_q;

	// second port only used by ecall for mcause
	assign csr_wen2 = out_valid && is_ecall;
	assign csr_waddr2 = is_ecall ? exu_pkg::CSR_MCAUSE : '0;
	assign csr_wdata2 = is_ecall ? exu_pkg::ECALL_CAUSE : '0;

	// a master response must belong to the memory op held in the stage
	a_done_in_stage: assert property (@(posedge clk) disable iff (rst)
		(load_done |-> stage_valid && is_load) and
		(store_done |-> stage_valid && is_store));

endmodule

// ==== exu_load_master.sv ====
`timescale 1ns/1ps

module exu_load_master (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  exu_pkg::data_t           addr,
	input  exu_pkg::load_kind_e      kind,
	output mem_pkg::addr_t           araddr,
	output logic                     arvalid,
	input  logic                     arready,
	input  exu_pkg::data_t           rdata,
	input  mem_pkg::resp_t           rresp,
	input  logic                     rvalid,
	output logic                     rready,
	output logic                     load_done,
	output exu_pkg::data_t           load_data
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_WAIT_ARREADY,
		R_SHAKED_AR,
		R_WAIT_RVALID
	} state_e;

	state_e state;
	state_e state_next;
	exu_pkg::data_t lane;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= R_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			R_IDLE: begin
				if (start) begin
					state_next = arready ? R_SHAKED_AR : R_WAIT_ARREADY;
				end
			end
			R_WAIT_ARREADY: begin
				if (arready) begin
					state_next = R_SHAKED_AR;
				end
			end
			R_SHAKED_AR, R_WAIT_RVALID: begin
				state_next = rvalid ? R_IDLE : R_WAIT_RVALID;
			end
			default: state_next = R_IDLE;
		endcase
	end

	// address comes straight from the stage register, stable while held
	assign araddr = addr;
	assign arvalid = (state == R_IDLE && start) || state == R_WAIT_ARREADY;
	assign rready = state == R_SHAKED_AR || state == R_WAIT_RVALID;
	assign load_done = rvalid && rready;

	// move the addressed byte or halfword down to lane 0
	assign lane = rdata >> {addr[1:0], 3'b000};

	always_comb begin
		case (kind)
			exu_pkg::LD_LH: load_data = {{16{lane[15]}}, lane[15:0]};
			exu_pkg::LD_LHU: load_data = {16'b0, lane[15:0]};
			exu_pkg::LD_LB: load_data = {{24{lane[7]}}, lane[7:0]};
			exu_pkg::LD_LBU: load_data = {24'b0, lane[7:0]};
			default: load_data = rdata;
		endcase
	end

	a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

	a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
		load_done |-> rresp == mem_pkg::RESP_OKAY);

endmodule

// ==== exu_pkg.sv ====
package exu_pkg;

	typedef logic [31:0] data_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [11:0] csr_addr_t;

	// compare ops return 0 or 1 in bit 0
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_GE,
		ALU_LTU,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [2:0] {LD_NONE, LD_LW, LD_LH, LD_LHU, LD_LB, LD_LBU} load_kind_e;

	typedef enum logic [1:0] {ST_NONE, ST_SW, ST_SH, ST_SB} store_kind_e;

	typedef enum logic [1:0] {JMP_NONE, JMP_JAL, JMP_JALR} jump_kind_e;

	typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_ECALL} csr_kind_e;

	localparam csr_addr_t CSR_MEPC = 12'h341;
	localparam csr_addr_t CSR_MCAUSE = 12'h342;
	// environment call from M-mode
	localparam data_t ECALL_CAUSE = 32'd11;

endpackage

// ==== exu_store_master.sv ====
`timescale 1ns/1ps

module exu_store_master (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  exu_pkg::data_t           addr,
	input  exu_pkg::store_kind_e     kind,
	input  exu_pkg::data_t           data,
	output mem_pkg::addr_t           awaddr,
	output logic                     awvalid,
	input  logic                     awready,
	output exu_pkg::data_t           wdata,
	output mem_pkg::strb_t           wstrb,
	output logic                     wvalid,
	input  logic                     wready,
	input  mem_pkg::resp_t           bresp,
	input  logic                     bvalid,
	output logic                     bready,
	output logic                     store_done
);

	typedef enum logic [2:0] {
		W_IDLE,
		W_WAIT_AWREADY,
		W_SHAKED_AW,
		W_WAIT_WREADY,
		W_SHAKED_W,
		W_WAIT_BVALID
	} state_e;

	state_e state;
	state_e state_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= W_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// address first, then data, then wait for the response
	always_comb begin
		state_next = state;
		case (state)
			W_IDLE: begin
				if (start) begin
					state_next = awready ? W_SHAKED_AW : W_WAIT_AWREADY;
				end
			end
			W_WAIT_AWREADY: begin
				if (awready) begin
					state_next = W_SHAKED_AW;
				end
			end
			W_SHAKED_AW, W_WAIT_WREADY: begin
				state_next = wready ? W_SHAKED_W : W_WAIT_WREADY;
			end
			W_SHAKED_W, W_WAIT_BVALID: begin
				state_next = bvalid ? W_IDLE : W_WAIT_BVALID;
			end
			default: state_next = W_IDLE;
		endcase
	end

	assign awaddr = addr;
	assign awvalid = (state == W_IDLE && start) || state == W_WAIT_AWREADY;
	assign wvalid = state == W_SHAKED_AW || state == W_WAIT_WREADY;
	assign bready = state == W_SHAKED_W || state == W_WAIT_BVALID;
	assign store_done = bvalid && bready;

	// replicate into every lane, the strobes pick the right one
	always_comb begin
		case (kind)
			exu_pkg::ST_SB: begin
				wdata = {4{data[7:0]}};
				wstrb = 4'b0001 << addr[1:0];
			end
			exu_pkg::ST_SH: begin
				wdata = {2{data[15:0]}};
				wstrb = 4'b0011 << {addr[1], 1'b0};
			end
			default: begin
				wdata = data;
				wstrb = 4'b1111;
			end
		endcase
	end

	a_wvalid_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

	a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
		store_done |-> bresp == mem_pkg::RESP_OKAY);

endmodule

// ==== exu_top.sv ====
`timescale 1ns/1ps

module exu_top #(
	parameter int MEM_WORDS = 1024,
	parameter int RESP_LATENCY = 2
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	output logic                     in_allowin,
	input  exu_pkg::data_t           pc,
	input  exu_pkg::data_t           src1,
	input  exu_pkg::data_t           src2,
	input  exu_pkg::reg_idx_t        rd,
	input  exu_pkg::alu_op_e         alu_op,
	input  exu_pkg::load_kind_e      load_kind,
	input  exu_pkg::store_kind_e     store_kind,
	input  exu_pkg::data_t           store_data,
	input  exu_pkg::jump_kind_e      jump_kind,
	input  logic                     cond_branch,
	input  exu_pkg::data_t           branch_target,
	input  exu_pkg::csr_addr_t       csr_idx,
	input  exu_pkg::csr_kind_e       csr_kind,
	input  exu_pkg::data_t           csr_nextpc,
	input  logic                     csr_nextpc_taken,
	output logic                     out_valid,
	output logic                     nextpc_taken,
	output exu_pkg::data_t           nextpc,
	output logic                     rf_wen,
	output exu_pkg::reg_idx_t        rf_waddr,
	output exu_pkg::data_t           rf_wdata,
	output logic                     csr_wen,
	output exu_pkg::csr_addr_t       csr_waddr,
	output exu_pkg::data_t           csr_wdata,
	output logic                     csr_wen2,
	output exu_pkg::csr_addr_t       csr_waddr2,
	output exu_pkg::data_t           csr_wdata2
);

	// data memory bus between the stage and the sram
	mem_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	exu_pkg::data_t rdata;
	mem_pkg::resp_t rresp;
	logic rvalid;
	logic rready;
	mem_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	exu_pkg::data_t wdata;
	mem_pkg::strb_t wstrb;
	logic wvalid;
	logic wready;
	mem_pkg::resp_t bresp;
	logic bvalid;
	logic bready;

	exu exu_inst (.*);

	dsram #(
		.MEM_WORDS(MEM_WORDS),
		.RESP_LATENCY(RESP_LATENCY)
	) dsram_inst (.*);

endmodule

// ==== files.f ====
exu_pkg.sv
mem_pkg.sv
alu.sv
exu_load_master.sv
exu_store_master.sv
exu.sv
dsram.sv
exu_top.sv
tb_exu_top.sv

// ==== mem_pkg.sv ====
package mem_pkg;

	typedef logic [31:0] addr_t;

	// one strobe per byte lane
	typedef logic [3:0] strb_t;

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;

endpackage

// ==== tb_exu_top.sv ====
`timescale 1ns/1ps

module tb_exu_top;

	typedef struct packed {
		exu_pkg::data_t pc;
		exu_pkg::data_t src1;
		exu_pkg::data_t src2;
		exu_pkg::reg_idx_t rd;
		exu_pkg::alu_op_e alu_op;
		exu_pkg::load_kind_e load_kind;
		exu_pkg::store_kind_e store_kind;
		exu_pkg::data_t store_data;
		exu_pkg::jump_kind_e jump_kind;
		logic cond_branch;
		exu_pkg::data_t branch_target;
		exu_pkg::csr_addr_t csr_idx;
		exu_pkg::csr_kind_e csr_kind;
		exu_pkg::data_t csr_nextpc;
		logic csr_nextpc_taken;
	} instr_t;

	typedef struct packed {
		logic is_mem;
		logic nextpc_taken;
		exu_pkg::data_t nextpc;
		logic rf_wen;
		exu_pkg::reg_idx_t rf_waddr;
		exu_pkg::data_t rf_wdata;
		logic csr_wen;
		exu_pkg::csr_addr_t csr_waddr;
		exu_pkg::data_t csr_wdata;
		logic csr_wen2;
		exu_pkg::csr_addr_t csr_waddr2;
		exu_pkg::data_t csr_wdata2;
	} expect_t;

	// alu, branch, memory, csr and mix instruction counts
	localparam int N_INSTR = 64 + 24 + 72 + 12 + 100;
	localparam int CYCLE_LIMIT = 40 * N_INSTR + 100;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_allowin;
	exu_pkg::data_t pc;
	exu_pkg::data_t src1;
	exu_pkg::data_t src2;
	exu_pkg::reg_idx_t rd;
	exu_pkg::alu_op_e alu_op;
	exu_pkg::load_kind_e load_kind;
	exu_pkg::store_kind_e store_kind;
	exu_pkg::data_t store_data;
	exu_pkg::jump_kind_e jump_kind;
	logic cond_branch;
	exu_pkg::data_t branch_target;
	exu_pkg::csr_addr_t csr_idx;
	exu_pkg::csr_kind_e csr_kind;
	exu_pkg::data_t csr_nextpc;
	logic csr_nextpc_taken;
	logic out_valid;
	logic nextpc_taken;
	exu_pkg::data_t nextpc;
	logic rf_wen;
	exu_pkg::reg_idx_t rf_waddr;
	exu_pkg::data_t rf_wdata;
	logic csr_wen;
	exu_pkg::csr_addr_t csr_waddr;
	exu_pkg::data_t csr_wdata;
	logic csr_wen2;
	exu_pkg::csr_addr_t csr_waddr2;
	exu_pkg::data_t csr_wdata2;

	// shadow of the data sram, words 0x200 upward are used
	exu_pkg::data_t shadow [1024];
	expect_t exp_q[$];
	string name_q[$];
	int acc_q[$];
	int cycles = 0;
	int value_errors = 0;
	int proto_errors = 0;
	int mem_accepted = 0;
	int mem_completed = 0;
	expect_t cur;
	string cur_name;
	int cur_acc;

	exu_top #(
		.MEM_WORDS(1024),
		.RESP_LATENCY(2)
	) exu_top_inst (.*);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	task automatic check_data(input string name, input exu_pkg::data_t exp,
			input exu_pkg::data_t act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_reg(input string name, input exu_pkg::reg_idx_t exp,
			input exu_pkg::reg_idx_t act);
		if (exp !== act) begin
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_csr(input string name, input exu_pkg::csr_addr_t exp,
			input exu_pkg::csr_addr_t act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	function automatic exu_pkg::data_t ref_alu(input exu_pkg::alu_op_e op,
			input exu_pkg::data_t a, input exu_pkg::data_t b);
		case (op)
			exu_pkg::ALU_ADD: return a + b;
			exu_pkg::ALU_SUB: return a - b;
			exu_pkg::ALU_AND: return a & b;
			exu_pkg::ALU_OR: return a | b;
			exu_pkg::ALU_XOR: return a ^ b;
			exu_pkg::ALU_SLL: return a << b[4:0];
			exu_pkg::ALU_SRL: return a >> b[4:0];
			exu_pkg::ALU_SRA: return $signed(a) >>> b[4:0];
			exu_pkg::ALU_SLT, exu_pkg::ALU_LT: return {31'b0, $signed(a) < $signed(b)};
			exu_pkg::ALU_SLTU, exu_pkg::ALU_LTU: return {31'b0, a < b};
			exu_pkg::ALU_EQ: return {31'b0, a == b};
			exu_pkg::ALU_NE: return {31'b0, a != b};
			exu_pkg::ALU_GE: return {31'b0, $signed(a) >= $signed(b)};
			default: return {31'b0, a >= b};
		endcase
	endfunction

	// expected completion of one instruction, stores update the shadow
	function automatic expect_t reference(input instr_t ins);
		expect_t e;
		exu_pkg::data_t r;
		exu_pkg::data_t word;
		exu_pkg::data_t lane;
		logic [9:0] idx;
		logic [4:0] sh;
		e = '0;
		r = ref_alu(ins.alu_op, ins.src1, ins.src2);
		idx = r[11:2];
		sh = {r[1:0], 3'b000};
		word = shadow[idx];
		lane = word >> sh;
		e.is_mem = ins.load_kind != exu_pkg::LD_NONE || ins.store_kind != exu_pkg::ST_NONE;
		if (ins.store_kind != exu_pkg::ST_NONE) begin
			case (ins.store_kind)
				exu_pkg::ST_SW: word = ins.store_data;
				exu_pkg::ST_SH: word[{r[1], 4'b0000} +: 16] = ins.store_data[15:0];
				default: word[sh +: 8] = ins.store_data[7:0];
			endcase
			shadow[idx] = word;
		end
		e.nextpc_taken = ins.jump_kind != exu_pkg::JMP_NONE ||
			(ins.cond_branch && r[0]) || ins.csr_nextpc_taken;
		if (ins.jump_kind == exu_pkg::JMP_JAL) begin
			e.nextpc = r;
		end else if (ins.jump_kind == exu_pkg::JMP_JALR) begin
			e.nextpc = r & ~32'h1;
		end else if (ins.cond_branch && r[0]) begin
			e.nextpc = ins.branch_target;
		end else begin
			e.nextpc = ins.csr_nextpc;
		end
		e.rf_wen = ins.store_kind == exu_pkg::ST_NONE && !ins.cond_branch &&
			ins.csr_kind != exu_pkg::CSR_ECALL;
		e.rf_waddr = ins.rd;
		if (ins.jump_kind != exu_pkg::JMP_NONE) begin
			e.rf_wdata = ins.pc + 32'd4;
		end else if (ins.load_kind != exu_pkg::LD_NONE) begin
			case (ins.load_kind)
				exu_pkg::LD_LH: e.rf_wdata = {{16{lane[15]}}, lane[15:0]};
				exu_pkg::LD_LHU: e.rf_wdata = {16'b0, lane[15:0]};
				exu_pkg::LD_LB: e.rf_wdata = {{24{lane[7]}}, lane[7:0]};
				exu_pkg::LD_LBU: e.rf_wdata = {24'b0, lane[7:0]};
				default: e.rf_wdata = word;
			endcase
		end else if (ins.csr_kind == exu_pkg::CSR_RW || ins.csr_kind == exu_pkg::CSR_RS) begin
			e.rf_wdata = ins.src2;
		end else begin
			e.rf_wdata = r;
		end
		e.csr_wen = ins.csr_kind != exu_pkg::CSR_NONE;
		e.csr_waddr = ins.csr_idx;
		case (ins.csr_kind)
			exu_pkg::CSR_RW: e.csr_wdata = ins.src1;
			exu_pkg::CSR_RS: e.csr_wdata = ins.src1 | ins.src2;
			default: begin
				e.csr_waddr = exu_pkg::CSR_MEPC;
				e.csr_wdata = ins.pc;
			end
		endcase
		e.csr_wen2 = ins.csr_kind == exu_pkg::CSR_ECALL;
		e.csr_waddr2 = exu_pkg::CSR_MCAUSE;
		e.csr_wdata2 = exu_pkg::ECALL_CAUSE;
		return e;
	endfunction

	function automatic instr_t blank_instr();
		instr_t ins;
		ins = '0;
		ins.pc = $urandom & 32'hffff_fffc;
		ins.rd = 5'($urandom);
		ins.alu_op = exu_pkg::ALU_ADD;
		return ins;
	endfunction

	function automatic instr_t make_alu(input exu_pkg::alu_op_e op);
		instr_t ins;
		ins = blank_instr();
		ins.alu_op = op;
		ins.src1 = $urandom;
		// equal operands now and then for the compare ops
		ins.src2 = ($urandom % 4 == 0) ? ins.src1 : $urandom;
		return ins;
	endfunction

	function automatic instr_t make_branch(input int unsigned sel);
		instr_t ins;
		ins = blank_instr();
		ins.src1 = $urandom;
		ins.src2 = $urandom;
		case (sel % 4)
			0: begin
				ins.cond_branch = 1'b1;
				ins.alu_op = exu_pkg::alu_op_e'(4'(10 + $urandom % 6));
				ins.branch_target = $urandom & 32'hffff_fffc;
				if ($urandom % 3 == 0) begin
					ins.src2 = ins.src1;
				end
			end
			1: begin
				ins.jump_kind = exu_pkg::JMP_JAL;
				ins.src1 = ins.pc;
				ins.src2 = $urandom & 32'h000f_fffe;
			end
			2: ins.jump_kind = exu_pkg::JMP_JALR;
			default: begin
				ins.csr_nextpc_taken = 1'($urandom);
				ins.csr_nextpc = $urandom & 32'hffff_fffc;
			end
		endcase
		return ins;
	endfunction

	// word selects one of 16 pool words at 0x200, offset by size
	function automatic instr_t make_mem(input exu_pkg::load_kind_e lk,
			input exu_pkg::store_kind_e sk, input int unsigned word);
		instr_t ins;
		exu_pkg::data_t a;
		exu_pkg::data_t r;
		ins = blank_instr();
		a = 32'h200 + word * 4;
		if (lk == exu_pkg::LD_LH || lk == exu_pkg::LD_LHU || sk == exu_pkg::ST_SH) begin
			a = a + 2 * ($urandom % 2);
		end else if (lk == exu_pkg::LD_LB || lk == exu_pkg::LD_LBU || sk == exu_pkg::ST_SB) begin
			a = a + $urandom % 4;
		end
		r = $urandom;
		ins.src2 = {{20{r[11]}}, r[11:0]};
		ins.src1 = a - ins.src2;
		ins.load_kind = lk;
		ins.store_kind = sk;
		ins.store_data = $urandom;
		return ins;
	endfunction

	function automatic instr_t make_csr(input exu_pkg::csr_kind_e kind);
		instr_t ins;
		ins = blank_instr();
		ins.csr_kind = kind;
		ins.csr_idx = 12'($urandom);
		ins.alu_op = exu_pkg::ALU_OR;
		ins.src1 = $urandom;
		ins.src2 = $urandom;
		if (kind == exu_pkg::CSR_ECALL) begin
			ins.csr_nextpc_taken = 1'b1;
			ins.csr_nextpc = $urandom & 32'hffff_fffc;
		end
		return ins;
	endfunction

	// called right after a rising edge, returns right after the accepting edge
	task automatic issue(input instr_t ins, input string name);
		expect_t e;
		in_valid <= 1'b1;
		pc <= ins.pc;
		src1 <= ins.src1;
		src2 <= ins.src2;
		rd <= ins.rd;
		alu_op <= ins.alu_op;
		load_kind <= ins.load_kind;
		store_kind <= ins.store_kind;
		store_data <= ins.store_data;
		jump_kind <= ins.jump_kind;
		cond_branch <= ins.cond_branch;
		branch_target <= ins.branch_target;
		csr_idx <= ins.csr_idx;
		csr_kind <= ins.csr_kind;
		csr_nextpc <= ins.csr_nextpc;
		csr_nextpc_taken <= ins.csr_nextpc_taken;
		do begin
			@(negedge clk);
		end while (!in_allowin);
		e = reference(ins);
		exp_q.push_back(e);
		name_q.push_back(name);
		acc_q.push_back(cycles + 1);
		@(posedge clk);
		if (e.is_mem) begin
			mem_accepted++;
		end
	endtask

	task automatic idle(input int n);
		in_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	task automatic print_counts();
		$display("errors: %0d value, %0d protocol", value_errors, proto_errors);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			print_counts();
			$display("Simulation failed");
			$finish;
		end
	end

	// compare at the falling edge where all outputs are settled
	always @(negedge clk) begin
		if (!rst) begin
			if (mem_accepted != mem_completed && !out_valid) begin
				check_bit("in_allowin during memory access", 1'b0, in_allowin);
			end
			if (!out_valid) begin
				check_bit("write enable outside completion", 1'b0, rf_wen | csr_wen | csr_wen2);
			end else if (exp_q.size() == 0) begin
				$display("out_valid pulsed with no accepted instruction outstanding");
				proto_errors++;
			end else begin
				cur = exp_q.pop_front();
				cur_name = name_q.pop_front();
				cur_acc = acc_q.pop_front();
				if (cur.is_mem) begin
					mem_completed++;
				end else if (cycles != cur_acc) begin
					$display("ERR %s latency: expected %0d, actual %0d", cur_name,
						1, cycles - cur_acc + 1);
					value_errors++;
				end
				check_bit({cur_name, " rf_wen"}, cur.rf_wen, rf_wen);
				if (cur.rf_wen) begin
					check_reg({cur_name, " rf_waddr"}, cur.rf_waddr, rf_waddr);
					check_data({cur_name, " rf_wdata"}, cur.rf_wdata, rf_wdata);
				end
				check_bit({cur_name, " nextpc_taken"}, cur.nextpc_taken, nextpc_taken);
				if (cur.nextpc_taken) begin
					check_data({cur_name, " nextpc"}, cur.nextpc, nextpc);
				end
				check_bit({cur_name, " csr_wen"}, cur.csr_wen, csr_wen);
				if (cur.csr_wen) begin
					check_csr({cur_name, " csr_waddr"}, cur.csr_waddr, csr_waddr);
					check_data({cur_name, " csr_wdata"}, cur.csr_wdata, csr_wdata);
				end
				check_bit({cur_name, " csr_wen2"}, cur.csr_wen2, csr_wen2);
				if (cur.csr_wen2) begin
					check_csr({cur_name, " csr_waddr2"}, cur.csr_waddr2, csr_waddr2);
					check_data({cur_name, " csr_wdata2"}, cur.csr_wdata2, csr_wdata2);
				end
			end
		end
	end

	initial begin
		instr_t ins;
		int unsigned sel;
		int drain;
		void'($urandom(32'h96b26782));
		rst = 1'b1;
		in_valid = 1'b0;
		pc = '0;
		src1 = '0;
		src2 = '0;
		rd = '0;
		alu_op = exu_pkg::ALU_ADD;
		load_kind = exu_pkg::LD_NONE;
		store_kind = exu_pkg::ST_NONE;
		store_data = '0;
		jump_kind = exu_pkg::JMP_NONE;
		cond_branch = 1'b0;
		branch_target = '0;
		csr_idx = '0;
		csr_kind = exu_pkg::CSR_NONE;
		csr_nextpc = '0;
		csr_nextpc_taken = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// quiet stage after reset
		repeat (6) begin
			@(negedge clk);
			check_bit("reset out_valid", 1'b0, out_valid);
			check_bit("reset rf_wen", 1'b0, rf_wen);
			check_bit("reset csr_wen", 1'b0, csr_wen | csr_wen2);
			check_bit("reset in_allowin", 1'b1, in_allowin);
		end
		@(posedge clk);

		for (int i = 0; i < 64; i++) begin
			issue(make_alu(exu_pkg::alu_op_e'(4'(i))), "alu");
		end
		idle(3);
		for (int i = 0; i < 24; i++) begin
			issue(make_branch(i), "branch");
		end
		idle(3);

		// fill every pool word, then partial stores and all load kinds
		for (int k = 0; k < 16; k++) begin
			issue(make_mem(exu_pkg::LD_NONE, exu_pkg::ST_SW, k), "sw");
		end
		for (int k = 0; k < 8; k++) begin
			issue(make_mem(exu_pkg::LD_NONE, exu_pkg::ST_SH, k), "sh");
			issue(make_mem(exu_pkg::LD_NONE, exu_pkg::ST_SB, k), "sb");
			for (int j = 1; j < 6; j++) begin
				issue(make_mem(exu_pkg::load_kind_e'(3'(j)), exu_pkg::ST_NONE, k), "load");
			end
		end
		idle(3);

		for (int i = 0; i < 4; i++) begin
			issue(make_csr(exu_pkg::CSR_RW), "csrrw");
			issue(make_csr(exu_pkg::CSR_RS), "csrrs");
			issue(make_csr(exu_pkg::CSR_ECALL), "ecall");
		end
		idle(3);

		for (int i = 0; i < 100; i++) begin
			sel = $urandom % 5;
			case (sel)
				0: ins = make_alu(exu_pkg::alu_op_e'(4'($urandom)));
				1: ins = make_branch($urandom);
				2: ins = make_mem(exu_pkg::load_kind_e'(3'(1 + $urandom % 5)),
					exu_pkg::ST_NONE, $urandom % 16);
				3: ins = make_mem(exu_pkg::LD_NONE,
					exu_pkg::store_kind_e'(2'(1 + $urandom % 3)), $urandom % 16);
				default: ins = make_csr(exu_pkg::csr_kind_e'(2'(1 + $urandom % 3)));
			endcase
			issue(ins, "mix");
		end

		in_valid <= 1'b0;
		drain = 0;
		while (exp_q.size() != 0 && drain < 200) begin
			@(posedge clk);
			drain++;
		end
		repeat (3) @(posedge clk);
		if (exp_q.size() != 0) begin
			$display("%0d accepted instructions never completed", exp_q.size());
			proto_errors++;
		end
		print_counts();
		if (value_errors == 0 && proto_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
